// File: filelist.f
+incdir+.
lsu_fwd_pkg.sv
lsu_access_decode.sv
lsu_store_window.sv
lsu_fwd_match.sv
lsu_fwd_top.sv
lsu_fwd_checker.sv
lsu_fwd_properties.sv
tb_lsu_fwd.sv

// File: lsu_access_decode.sv
/* dc1 decode of size, byte enables and aligned store data; dc2 record register */
`timescale 1ns/100ps
`include "lsu_fwd_settings.svh"

module lsu_access_decode (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       op_valid,
   input  logic                       op_load,
   input  logic                       op_store,
   input  lsu_fwd_pkg::lsu_size_t     op_size,
   input  logic                       op_sideeffect,
   input  logic [`LSU_ADDR_W-1:0]     op_addr,
   input  logic [`LSU_DATA_W-1:0]     op_wdata,
   output lsu_fwd_pkg::lsu_op_t       op_dc2
);

   localparam int OFF_W = $clog2(`LSU_BYTES);

   logic [OFF_W-1:0]           size_m1;          // bytes in the access minus one
   logic [`LSU_BYTES-1:0]      byteen_dc1;
   logic [2*`LSU_BYTES-1:0]    byteen_ext_dc1;
   logic [`LSU_DATA_W-1:0]     wdata_masked;
   logic [2*`LSU_DATA_W-1:0]   wdata_ext_dc1;
   lsu_fwd_pkg::lsu_op_t       op_dc1;

   always_comb begin
      case (op_size)
         lsu_fwd_pkg::LSU_SIZE_BYTE: size_m1 = OFF_W'(0);
         lsu_fwd_pkg::LSU_SIZE_HALF: size_m1 = OFF_W'(1);
         default:                    size_m1 = OFF_W'(3);
      endcase
   end

   // enables start at byte 0, unused store bytes are zeroed
   always_comb begin
      for (int b = 0; b < `LSU_BYTES; b++) begin
         byteen_dc1[b]          = (b <= int'(size_m1));
         wdata_masked[8*b +: 8] = op_wdata[8*b +: 8] & {8{byteen_dc1[b]}};
      end
   end

   //************************************************************************
   // move enables and data into the two-word window by the byte offset
   //************************************************************************
   assign byteen_ext_dc1 = {{`LSU_BYTES{1'b0}}, byteen_dc1} << op_addr[OFF_W-1:0];
   assign wdata_ext_dc1  = {{`LSU_DATA_W{1'b0}}, wdata_masked} << {op_addr[OFF_W-1:0], 3'b000};

   always_comb begin
      op_dc1.valid      = op_valid;
      op_dc1.load       = op_load;
      op_dc1.store      = op_store;
      op_dc1.sideeffect = op_sideeffect;
      op_dc1.addr       = op_addr;
      op_dc1.end_addr   = op_addr + `LSU_ADDR_W'(size_m1);
      op_dc1.byteen_lo  = byteen_ext_dc1[`LSU_BYTES-1:0];
      op_dc1.byteen_hi  = byteen_ext_dc1[2*`LSU_BYTES-1:`LSU_BYTES];
      op_dc1.data_lo    = wdata_ext_dc1[`LSU_DATA_W-1:0];
      op_dc1.data_hi    = wdata_ext_dc1[2*`LSU_DATA_W-1:`LSU_DATA_W];
   end

   // dc2 stage register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         op_dc2.valid <= 1'b0;
      end else begin
         op_dc2 <= op_dc1;
      end
   end

endmodule

// File: lsu_fwd_checker.sv
/* reference model of store-to-load forwarding and the process that compares
   the DUT's load results with it */
`timescale 1ns/100ps
`include "lsu_fwd_settings.svh"

module lsu_fwd_checker #(
   parameter int MEM_BYTES = 128
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     op_valid,
   input  logic                     op_load,
   input  logic                     op_store,
   input  lsu_fwd_pkg::lsu_size_t   op_size,
   input  logic                     op_sideeffect,
   input  logic [`LSU_ADDR_W-1:0]   op_addr,
   input  logic [`LSU_DATA_W-1:0]   op_wdata,
   input  logic [7:0]               mem [MEM_BYTES],
   input  logic                     load_valid,
   input  logic                     load_full_hit,
   input  logic [`LSU_DATA_W-1:0]   load_data,
   output int                       errors,
   output int                       loads_seen,
   output int                       fwd_seen
);

   localparam int DEPTH  = `LSU_WINDOW_DEPTH;
   localparam int HIST   = DEPTH + 2;     // newest slot, dc3 load, then its window
   localparam int MEM_AW = $clog2(MEM_BYTES);

   typedef struct packed {
      logic                     valid;
      logic                     load;
      logic                     store;
      logic                     sideeffect;
      lsu_fwd_pkg::lsu_size_t   size;
      logic [`LSU_ADDR_W-1:0]   addr;
      logic [`LSU_DATA_W-1:0]   wdata;
   } slot_t;

   slot_t                    now_slot;
   slot_t                    hist [HIST];
   slot_t [DEPTH-1:0]        win_now;        // [0] is the youngest older slot
   logic                     armed;
   logic                     exp_valid;
   logic [`LSU_DATA_W:0]     exp_result;     // full hit on top of the data
   int                       err_count = 0;
   int                       load_count = 0;
   int                       fwd_count = 0;

   function automatic int size_bytes(lsu_fwd_pkg::lsu_size_t size);
      case (size)
         lsu_fwd_pkg::LSU_SIZE_BYTE: return 1;
         lsu_fwd_pkg::LSU_SIZE_HALF: return 2;
         default:                    return 4;
      endcase
   endfunction

   //**************************************************************************
   // per load byte, the youngest store covering that address supplies it
   //**************************************************************************
   function automatic logic [`LSU_DATA_W:0] expect_load(slot_t ld, slot_t [DEPTH-1:0] win);
      logic [`LSU_DATA_W-1:0] fwd_data;
      logic [`LSU_DATA_W-1:0] mem_data;
      logic [`LSU_ADDR_W-1:0] a;
      logic [MEM_AW-1:0]      idx;
      logic                   covered;
      logic                   all_covered;
      int                     off;
      fwd_data    = '0;
      mem_data    = '0;
      all_covered = 1'b1;
      for (int i = 0; i < size_bytes(ld.size); i++) begin
         a   = ld.addr + `LSU_ADDR_W'(i);
         idx = a[MEM_AW-1:0];
         mem_data[8*i +: 8] = mem[idx];
         covered = 1'b0;
         for (int s = 0; s < DEPTH; s++) begin
            off = int'(a - win[s].addr);
            if (!covered && win[s].valid && win[s].store &&
                a >= win[s].addr && off < size_bytes(win[s].size)) begin
               fwd_data[8*i +: 8] = win[s].wdata[8*off +: 8];
               covered = 1'b1;
            end
         end
         all_covered = all_covered & covered;
      end
      if (all_covered && !ld.sideeffect) begin
         return {1'b1, fwd_data};
      end else begin
         return {1'b0, mem_data};
      end
   endfunction

   always_comb begin
      now_slot.valid      = rst_n & op_valid;     // nothing enters during reset
      now_slot.load       = op_load;
      now_slot.store      = op_store;
      now_slot.sideeffect = op_sideeffect;
      now_slot.size       = op_size;
      now_slot.addr       = op_addr;
      now_slot.wdata      = op_wdata;
      for (int s = 0; s < DEPTH; s++) begin
         win_now[s] = hist[s+2];
      end
   end

   always @(posedge clk) begin
      hist[0] <= now_slot;
      for (int h = 1; h < HIST; h++) begin
         hist[h] <= hist[h-1];
      end
      armed <= rst_n;
   end

   // outputs are compared mid-cycle
   always @(negedge clk) begin
      if (armed) begin
         exp_valid = hist[1].valid & hist[1].load;
         if (load_valid !== exp_valid) begin
            $display("Error at %0t ns: load_valid is %b, expected %b", $time, load_valid,
                     exp_valid);
            err_count++;
         end
         if (exp_valid) begin
            exp_result = expect_load(hist[1], win_now);
            load_count++;
            if (exp_result[`LSU_DATA_W]) begin
               fwd_count++;
            end
            if (load_full_hit !== exp_result[`LSU_DATA_W] ||
                load_data !== exp_result[`LSU_DATA_W-1:0]) begin
               $display("Error at %0t ns: load at %h gave hit %b data %h, expected hit %b data %h",
                        $time, hist[1].addr, load_full_hit, load_data,
                        exp_result[`LSU_DATA_W], exp_result[`LSU_DATA_W-1:0]);
               err_count++;
            end
         end else if (load_full_hit !== 1'b0) begin
            $display("Error at %0t ns: load_full_hit high without a load", $time);
            err_count++;
         end
      end
   end

   assign errors     = err_count;
   assign loads_seen = load_count;
   assign fwd_seen   = fwd_count;

endmodule

// File: lsu_fwd_match.sv
/* dc2 byte matching against the dc3..dc5 stores, youngest-first data select,
   full-hit detection, dc3 result register and the return mux */
`timescale 1ns/100ps
`include "lsu_fwd_settings.svh"

module lsu_fwd_match (
   input  logic                          clk,
   input  logic                          rst_n,
   input  lsu_fwd_pkg::lsu_op_t          op_dc2,
   input  lsu_fwd_pkg::lsu_op_window_t   window,
   input  logic [`LSU_DATA_W-1:0]        bus_rdata,      // memory bytes of the dc3 load
   output logic                          load_valid,
   output logic                          load_full_hit,
   output logic [`LSU_DATA_W-1:0]        load_data
);

   localparam int OFF_W = $clog2(`LSU_BYTES);
   localparam int DEPTH = `LSU_WINDOW_DEPTH;

   logic                                   ld_dc2;
   logic [DEPTH-1:0]                       st_vld;
   logic [DEPTH-1:0]                       addr_hit_lo_lo, addr_hit_lo_hi;
   logic [DEPTH-1:0]                       addr_hit_hi_lo, addr_hit_hi_hi;
   logic [DEPTH-1:0][`LSU_BYTES-1:0]       byte_hit_lo, byte_hit_hi;
   logic [DEPTH-1:0][`LSU_DATA_W-1:0]      pipe_data_lo, pipe_data_hi;
   logic [`LSU_BYTES-1:0]                  ld_byte_hit_lo, ld_byte_hit_hi;
   logic [`LSU_DATA_W-1:0]                 fwd_lo, fwd_hi;
   logic [2*`LSU_DATA_W-1:0]               fwd_win;
   logic [`LSU_DATA_W-1:0]                 fwd_data_dc2, fwd_data_dc3;
   logic                                   full_hit_lo, full_hit_hi, full_hit_dc2;

   assign ld_dc2 = op_dc2.valid & op_dc2.load;

   //************************************************************************
   // word address compare, per stage and per low/high pairing
   // first suffix is the store word, second the load word
   //************************************************************************
   for (genvar s = 0; s < DEPTH; s++) begin : g_stage
      assign st_vld[s] = ld_dc2 & window[s].valid & window[s].store;

      assign addr_hit_lo_lo[s] = st_vld[s] &
         (op_dc2.addr[`LSU_ADDR_W-1:OFF_W] == window[s].addr[`LSU_ADDR_W-1:OFF_W]);
      assign addr_hit_lo_hi[s] = st_vld[s] &
         (op_dc2.end_addr[`LSU_ADDR_W-1:OFF_W] == window[s].addr[`LSU_ADDR_W-1:OFF_W]);
      assign addr_hit_hi_lo[s] = st_vld[s] &
         (op_dc2.addr[`LSU_ADDR_W-1:OFF_W] == window[s].end_addr[`LSU_ADDR_W-1:OFF_W]);
      assign addr_hit_hi_hi[s] = st_vld[s] &
         (op_dc2.end_addr[`LSU_ADDR_W-1:OFF_W] == window[s].end_addr[`LSU_ADDR_W-1:OFF_W]);

      for (genvar b = 0; b < `LSU_BYTES; b++) begin : g_byte
         logic hit_lo_lo, hit_lo_hi, hit_hi_lo, hit_hi_hi;

         assign hit_lo_lo = addr_hit_lo_lo[s] & window[s].byteen_lo[b] & op_dc2.byteen_lo[b];
         assign hit_lo_hi = addr_hit_lo_hi[s] & window[s].byteen_lo[b] & op_dc2.byteen_hi[b];
         assign hit_hi_lo = addr_hit_hi_lo[s] & window[s].byteen_hi[b] & op_dc2.byteen_lo[b];
         assign hit_hi_hi = addr_hit_hi_hi[s] & window[s].byteen_hi[b] & op_dc2.byteen_hi[b];

         assign byte_hit_lo[s][b] = hit_lo_lo | hit_hi_lo;
         assign byte_hit_hi[s][b] = hit_lo_hi | hit_hi_hi;

         // at most one pairing hits a given load byte of one store
         assign pipe_data_lo[s][8*b +: 8] = ({8{hit_lo_lo}} & window[s].data_lo[8*b +: 8]) |
                                            ({8{hit_hi_lo}} & window[s].data_hi[8*b +: 8]);
         assign pipe_data_hi[s][8*b +: 8] = ({8{hit_lo_hi}} & window[s].data_lo[8*b +: 8]) |
                                            ({8{hit_hi_hi}} & window[s].data_hi[8*b +: 8]);
      end
   end

   //************************************************************************
   // per-byte select, walked oldest first so dc3 ends up on top
   //************************************************************************
   always_comb begin
      fwd_lo         = '0;
      fwd_hi         = '0;
      ld_byte_hit_lo = '0;
      ld_byte_hit_hi = '0;
      for (int s = DEPTH-1; s >= 0; s--) begin
         for (int b = 0; b < `LSU_BYTES; b++) begin
            if (byte_hit_lo[s][b]) begin
               fwd_lo[8*b +: 8] = pipe_data_lo[s][8*b +: 8];
            end
            if (byte_hit_hi[s][b]) begin
               fwd_hi[8*b +: 8] = pipe_data_hi[s][8*b +: 8];
            end
         end
         ld_byte_hit_lo = ld_byte_hit_lo | byte_hit_lo[s];
         ld_byte_hit_hi = ld_byte_hit_hi | byte_hit_hi[s];
      end
   end

   // every enabled load byte must be covered
   assign full_hit_lo  = &(ld_byte_hit_lo | ~op_dc2.byteen_lo);
   assign full_hit_hi  = &(ld_byte_hit_hi | ~op_dc2.byteen_hi);
   assign full_hit_dc2 = full_hit_lo & full_hit_hi & ld_dc2 & ~op_dc2.sideeffect;

   // bring the first load byte down to bit 0, bytes past the size stay zero
   assign fwd_win      = {fwd_hi, fwd_lo};
   assign fwd_data_dc2 = `LSU_DATA_W'(fwd_win >> {op_dc2.addr[OFF_W-1:0], 3'b000});

   //************************************************************************
   // dc3 register and return mux
   //************************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         load_valid    <= 1'b0;
         load_full_hit <= 1'b0;
      end else begin
         load_valid    <= ld_dc2;
         load_full_hit <= full_hit_dc2;
      end
   end

   always_ff @(posedge clk) begin
      fwd_data_dc3 <= fwd_data_dc2;
   end

   assign load_data = load_full_hit ? fwd_data_dc3 : bus_rdata;   // forwarded or from the bus

endmodule

// File: lsu_fwd_pkg.sv
/* access size type, decoded stage record and the dc3..dc5 window type */
`include "lsu_fwd_settings.svh"

package lsu_fwd_pkg;

   typedef enum logic [1:0] {
      LSU_SIZE_BYTE = 2'b00,
      LSU_SIZE_HALF = 2'b01,
      LSU_SIZE_WORD = 2'b10
   } lsu_size_t;

   //************************************************************************
   // one memory operation after decode, as it moves down dc2..dc5
   //************************************************************************
   typedef struct packed {
      logic                     valid;
      logic                     load;
      logic                     store;
      logic                     sideeffect;   // never forwarded to
      logic [`LSU_ADDR_W-1:0]   addr;         // first byte
      logic [`LSU_ADDR_W-1:0]   end_addr;     // last byte
      logic [`LSU_BYTES-1:0]    byteen_lo;    // enables in the word of addr
      logic [`LSU_BYTES-1:0]    byteen_hi;    // enables in the next word
      logic [`LSU_DATA_W-1:0]   data_lo;      // store data, shifted into place
      logic [`LSU_DATA_W-1:0]   data_hi;
   } lsu_op_t;

   // index 0 is dc3, the youngest older operation
   typedef lsu_op_t [`LSU_WINDOW_DEPTH-1:0] lsu_op_window_t;

endpackage

// File: lsu_fwd_properties.sv
/* concurrent assertions on the load return, bound into lsu_fwd_top */
`timescale 1ns/100ps

module lsu_fwd_properties (
   input logic clk,
   input logic rst_n,
   input logic op_valid,
   input logic op_load,
   input logic op_store,
   input logic op_sideeffect,
   input logic load_valid,
   input logic load_full_hit
);

   // one result for each load, exactly two cycles on
   a_load_latency: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) && $past(rst_n, 2) |-> load_valid == $past(op_valid && op_load, 2))
      else $error("load_valid does not follow a load by two cycles");

   // a full hit needs a store in one of the three slots before the load
   a_hit_needs_store: assert property (@(posedge clk) disable iff (!rst_n)
      load_full_hit |-> $past(op_valid && op_store, 3) || $past(op_valid && op_store, 4) ||
                        $past(op_valid && op_store, 5))
      else $error("load_full_hit high with no store in the window");

   a_no_sideeffect_fwd: assert property (@(posedge clk) disable iff (!rst_n)
      load_full_hit |-> !$past(op_sideeffect, 2))
      else $error("side-effect load was forwarded");

   a_reset_clears: assert property (@(posedge clk)
      !rst_n |=> !load_valid && !load_full_hit)
      else $error("load outputs not cleared by reset");

endmodule

bind lsu_fwd_top lsu_fwd_properties props0 (
   .clk           (clk),
   .rst_n         (rst_n),
   .op_valid      (op_valid),
   .op_load       (op_load),
   .op_store      (op_store),
   .op_sideeffect (op_sideeffect),
   .load_valid    (load_valid),
   .load_full_hit (load_full_hit)
);

// File: lsu_fwd_settings.svh
/* widths and window depth shared by the forwarding pipeline */
`ifndef LSU_FWD_SETTINGS_SVH
`define LSU_FWD_SETTINGS_SVH

`define LSU_ADDR_W        32   // byte address
`define LSU_DATA_W        32   // one bus word
`define LSU_BYTES         4    // bytes per word

// older stages searched by a dc2 load (dc3, dc4, dc5)
`define LSU_WINDOW_DEPTH  3

`endif

// File: lsu_fwd_top.sv
/* store-to-load forwarding pipeline top, decode -> window -> match */
`timescale 1ns/100ps
`include "lsu_fwd_settings.svh"

module lsu_fwd_top (
   input  logic                       clk,
   input  logic                       rst_n,

   // dc1 operation, one per cycle
   input  logic                       op_valid,
   input  logic                       op_load,
   input  logic                       op_store,
   input  lsu_fwd_pkg::lsu_size_t     op_size,
   input  logic                       op_sideeffect,
   input  logic [`LSU_ADDR_W-1:0]     op_addr,
   input  logic [`LSU_DATA_W-1:0]     op_wdata,

   // dc3 load return
   input  logic [`LSU_DATA_W-1:0]     bus_rdata,
   output logic                       load_valid,
   output logic                       load_full_hit,
   output logic [`LSU_DATA_W-1:0]     load_data
);

   lsu_fwd_pkg::lsu_op_t          op_dc2;
   lsu_fwd_pkg::lsu_op_window_t   window;    // dc3..dc5

   lsu_access_decode decode0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .op_valid      (op_valid),
      .op_load       (op_load),
      .op_store      (op_store),
      .op_size       (op_size),
      .op_sideeffect (op_sideeffect),
      .op_addr       (op_addr),
      .op_wdata      (op_wdata),
      .op_dc2        (op_dc2)
   );

   lsu_store_window window0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .op_dc2        (op_dc2),
      .window        (window)
   );

   lsu_fwd_match match0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .op_dc2        (op_dc2),
      .window        (window),
      .bus_rdata     (bus_rdata),
      .load_valid    (load_valid),
      .load_full_hit (load_full_hit),
      .load_data     (load_data)
   );

endmodule

// File: lsu_store_window.sv
/* dc3, dc4 and dc5 operation records, shifted along every cycle */
`timescale 1ns/100ps
`include "lsu_fwd_settings.svh"

module lsu_store_window (
   input  logic                          clk,
   input  logic                          rst_n,
   input  lsu_fwd_pkg::lsu_op_t          op_dc2,    // enters dc3 next cycle
   output lsu_fwd_pkg::lsu_op_window_t   window     // [0] dc3 .. [2] dc5
);

   //************************************************************************
   // shift chain, no stall and no flush
   //************************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int s = 0; s < `LSU_WINDOW_DEPTH; s++) begin
            window[s].valid <= 1'b0;
         end
      end else begin
         window[0] <= op_dc2;
         for (int s = 1; s < `LSU_WINDOW_DEPTH; s++) begin
            window[s] <= window[s-1];    // older moves one stage on
         end
      end
   end

endmodule

// File: run.sh
#!/bin/sh
# build the forwarding testbench with Verilator, run it and scan its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_lsu_fwd \
   -o sim_lsu_fwd -f filelist.f \
   || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/sim_lsu_fwd) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED" && exit 0 || exit 1

// File: tb_lsu_fwd.sv
/* testbench top: clock, reset, directed and random operations, byte memory
   behind bus_rdata, watchdog and closing report */
`timescale 1ns/100ps
`include "lsu_fwd_settings.svh"

module tb_lsu_fwd;

   localparam int MEM_BYTES   = 128;
   localparam int MEM_AW      = $clog2(MEM_BYTES);
   localparam int NUM_TESTS   = 400;          // random operations after the directed ones
   localparam int CLK_NS      = 4;
   localparam int WATCHDOG_NS = (NUM_TESTS + 100) * CLK_NS + 200;

   logic                     clk, rst_n;
   logic                     op_valid, op_load, op_store, op_sideeffect;
   lsu_fwd_pkg::lsu_size_t   op_size;
   logic [`LSU_ADDR_W-1:0]   op_addr;
   logic [`LSU_DATA_W-1:0]   op_wdata, bus_rdata, load_data;
   logic                     load_valid, load_full_hit;
   logic [7:0]               mem [MEM_BYTES];
   int                       errors, loads_seen, fwd_seen;
   integer                   seed = 8;

   // the two operations issued before the current one, [1] is in dc3
   logic                     pipe_load [2];
   int                       pipe_bytes [2];
   logic [`LSU_ADDR_W-1:0]   pipe_addr [2];

   lsu_fwd_top dut0 (.*);

   lsu_fwd_checker #(.MEM_BYTES(MEM_BYTES)) chk0 (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_NS/2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog timeout, the stimulus did not finish in time");
      $display("TESTBENCH FAILED");
      $finish;
   end

   function automatic int access_bytes(lsu_fwd_pkg::lsu_size_t sz);
      case (sz)
         lsu_fwd_pkg::LSU_SIZE_BYTE: return 1;
         lsu_fwd_pkg::LSU_SIZE_HALF: return 2;
         default:                    return 4;
      endcase
   endfunction

   // memory bytes of the load now in dc3, zero-extended
   task automatic update_bus;
      logic [`LSU_DATA_W-1:0] word;
      logic [MEM_AW-1:0]      idx;
      word = '0;
      if (pipe_load[1]) begin
         for (int i = 0; i < pipe_bytes[1]; i++) begin
            idx = pipe_addr[1][MEM_AW-1:0] + MEM_AW'(i);
            word[8*i +: 8] = mem[idx];
         end
      end
      bus_rdata     = word;
      pipe_load[1]  = pipe_load[0];
      pipe_bytes[1] = pipe_bytes[0];
      pipe_addr[1]  = pipe_addr[0];
   endtask

   task automatic issue(input logic v, input logic ld, input logic st,
                        input lsu_fwd_pkg::lsu_size_t sz, input logic se,
                        input logic [`LSU_ADDR_W-1:0] addr, input logic [`LSU_DATA_W-1:0] wd);
      @(posedge clk);
      #1;
      update_bus();
      pipe_load[0]  = v & ld;
      pipe_bytes[0] = access_bytes(sz);
      pipe_addr[0]  = addr;
      op_valid      = v;
      op_load       = ld;
      op_store      = st;
      op_size       = sz;
      op_sideeffect = se;
      op_addr       = addr;
      op_wdata      = wd;
   endtask

   task automatic store_op(input lsu_fwd_pkg::lsu_size_t sz, input logic [31:0] addr,
                           input logic [31:0] wd);
      issue(1'b1, 1'b0, 1'b1, sz, 1'b0, addr, wd);
   endtask

   task automatic load_op(input lsu_fwd_pkg::lsu_size_t sz, input logic [31:0] addr,
                          input logic se);
      issue(1'b1, 1'b1, 1'b0, sz, se, addr, '0);
   endtask

   task automatic idle_cycle;
      issue(1'b0, 1'b0, 1'b0, lsu_fwd_pkg::LSU_SIZE_WORD, 1'b0, '0, '0);
   endtask

   task automatic random_op;
      logic [31:0]            r;
      logic [31:0]            wd;
      lsu_fwd_pkg::lsu_size_t sz;
      r  = $random(seed);
      wd = $random(seed);
      case (r[1:0])
         2'd0:    sz = lsu_fwd_pkg::LSU_SIZE_BYTE;
         2'd1:    sz = lsu_fwd_pkg::LSU_SIZE_HALF;
         default: sz = lsu_fwd_pkg::LSU_SIZE_WORD;
      endcase
      // small address range so that stores and loads overlap often
      issue(r[5:3] != 3'd0, r[2], !r[2], sz, r[2] && r[8:6] == 3'd0, {28'd0, r[12:9]}, wd);
   endtask

   initial begin
      for (int i = 0; i < MEM_BYTES; i++) begin
         mem[i] = 8'($random(seed));
      end
      rst_n = 1'b0;
      op_valid = 1'b0;
      op_load = 1'b0;
      op_store = 1'b0;
      op_size = lsu_fwd_pkg::LSU_SIZE_WORD;
      op_sideeffect = 1'b0;
      op_addr = '0;
      op_wdata = '0;
      bus_rdata = '0;
      for (int p = 0; p < 2; p++) begin
         pipe_load[p] = 1'b0;
         pipe_bytes[p] = 4;
         pipe_addr[p] = '0;
      end
      repeat (4) @(posedge clk);
      #1 rst_n = 1'b1;

      //***********************************************************************
      // directed cases
      //***********************************************************************
      store_op(lsu_fwd_pkg::LSU_SIZE_WORD, 32'h10, 32'h1122_3344);
      load_op(lsu_fwd_pkg::LSU_SIZE_WORD, 32'h10, 1'b0);        // aligned word hit
      store_op(lsu_fwd_pkg::LSU_SIZE_WORD, 32'h20, 32'ha0a1_a2a3);
      store_op(lsu_fwd_pkg::LSU_SIZE_BYTE, 32'h44, 32'h0000_0055);
      store_op(lsu_fwd_pkg::LSU_SIZE_HALF, 32'h21, 32'h0000_b1b2);
      load_op(lsu_fwd_pkg::LSU_SIZE_WORD, 32'h20, 1'b0);        // dc3 over dc5
      store_op(lsu_fwd_pkg::LSU_SIZE_WORD, 32'h30, 32'hc0c1_c2c3);
      store_op(lsu_fwd_pkg::LSU_SIZE_WORD, 32'h34, 32'hd0d1_d2d3);
      load_op(lsu_fwd_pkg::LSU_SIZE_WORD, 32'h32, 1'b0);        // crosses into 0x34
      store_op(lsu_fwd_pkg::LSU_SIZE_HALF, 32'h38, 32'h0000_e1e2);
      load_op(lsu_fwd_pkg::LSU_SIZE_WORD, 32'h37, 1'b0);        // byte 0x3a uncovered
      store_op(lsu_fwd_pkg::LSU_SIZE_WORD, 32'h50, 32'hf0f1_f2f3);
      load_op(lsu_fwd_pkg::LSU_SIZE_WORD, 32'h50, 1'b1);        // side-effect
      store_op(lsu_fwd_pkg::LSU_SIZE_WORD, 32'h60, 32'h6060_6161);
      repeat (2) idle_cycle();
      load_op(lsu_fwd_pkg::LSU_SIZE_WORD, 32'h60, 1'b0);        // store still in dc5
      store_op(lsu_fwd_pkg::LSU_SIZE_WORD, 32'h64, 32'h6464_6565);
      repeat (3) idle_cycle();
      load_op(lsu_fwd_pkg::LSU_SIZE_WORD, 32'h64, 1'b0);        // store has left
      idle_cycle();

      for (int t = 0; t < NUM_TESTS; t++) begin
         random_op();
      end
      repeat (4) idle_cycle();     // drain the 2-cycle load latency
      @(posedge clk);

      $display("loads checked %0d, forwarded %0d, errors %0d", loads_seen, fwd_seen, errors);
      if (errors == 0 && loads_seen > 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule
